// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_top
RTL_TOP    := platform_shim
FILELIST   := sources.f
BUILD_DIR  := obj_dir
LOG        := sim.log
SIM_FLAGS  := --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# The log decides the outcome; a missing final line also counts as failure
run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "Result: PASSED" $(LOG) || (echo "Simulation ended without a result"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/mem_bank_model.sv
`include "ccip_shim_macros.svh"

module mem_bank_model
(
    input  logic ccip_to_afu,
    input  ccip_shim_pkg::t_mem_req req,
    output ccip_shim_pkg::t_mem_rsp rsp
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int DEPTH = 1 << `SHIM_BANK_ADDR_W;
    localparam int LAT = 3;

    logic [`SHIM_MEM_DATA_W-1:0] mem [DEPTH];
    logic [LAT-1:0] vld_pipe = '0;
    logic [`SHIM_MEM_DATA_W-1:0] data_pipe [LAT];
    logic wait_q = 1'b1;
    logic vld_q = 1'b0;
    logic [`SHIM_MEM_DATA_W-1:0] data_q = '0;

    // Field order follows t_mem_rsp: waitrequest, readdatavalid, readdata
    assign rsp = {wait_q, vld_q, data_q};

    // Every word starts out different, so a stale read never looks like a pattern word
    initial
    begin
        for (int a = 0; a < DEPTH; a++)
            mem[a] = {32'hbad0_0000 + a, 32'h0000_5a00 ^ a};
    end

    // Accept beats on the rising edge; reads enter a fixed latency pipe
    always @(posedge ccip_to_afu)
    begin
        vld_pipe <= {vld_pipe[LAT-2:0], req.read && !wait_q};
        data_pipe[0] <= mem[req.address[`SHIM_BANK_ADDR_W-1:0]];
        for (int s = 1; s < LAT; s++)
            data_pipe[s] <= data_pipe[s-1];
        if (req.write && !wait_q)
            mem[req.address[`SHIM_BANK_ADDR_W-1:0]] <= req.writedata;
    end

    // Outputs change on the falling edge, about a third of cycles stall
    always @(negedge ccip_to_afu)
    begin
        wait_q <= ($urandom_range(2) == 0);
        vld_q <= vld_pipe[LAT-1];
        data_q <= vld_pipe[LAT-1] ? data_pipe[LAT-1] : '0;
    end

    // Backdoor bit flip in the low half, so a later read of this word mismatches
    task automatic corrupt(input logic [`SHIM_BANK_ADDR_W-1:0] addr);
        mem[addr] <= mem[addr] ^ 64'h1;
    endtask

endmodule

// File: dv/tb_top.sv
`include "ccip_shim_macros.svh"

module tb_top;
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] SEED = 32'had86_7dca;
    localparam logic [31:0] SEED_A = 32'h1234_5678;
    // Close to the top so the low half wraps inside the range
    localparam logic [31:0] SEED_B = 32'hffff_fff0;
    localparam logic [31:0] SEED_C = 32'h0bad_cafe;
    localparam int T3_WORDS = 40;
    localparam int T4_WORDS = 32;
    localparam int T5_WORDS = 24;
    // Fill and check of tests 3 and 4, the joint run of test 5 and the check of test 6
    localparam int TOTAL_WORDS = 2 * T3_WORDS + 2 * T4_WORDS + T5_WORDS + T3_WORDS + T5_WORDS;
    localparam int CYCLE_LIMIT = 8 * TOTAL_WORDS + 2000;

    logic ccip_to_afu = 1'b0;
    logic reset;
    ccip_shim_pkg::t_mmio_req mmio_req;
    ccip_shim_pkg::t_mmio_rsp mmio_rsp;
    ccip_shim_pkg::t_mem_req bank_req[`SHIM_NUM_BANKS];
    ccip_shim_pkg::t_mem_rsp bank_rsp[`SHIM_NUM_BANKS];

    // Scoreboard for MMIO answers and for the fill that is running
    logic [63:0] exp_rsp;
    logic rd_check;
    logic quiet;
    logic [`SHIM_BANK_ADDR_W:0] fill_base;
    logic [15:0] fill_count;
    logic [31:0] fill_seed;
    logic exp_fill_done;
    logic exp_check_done;
    logic [15:0] exp_err;
    int wr_total = 0;
    int rd_total = 0;
    int wr_mark;
    int rd_mark;
    int cycles = 0;
    int errors = 0;
    int err_mark = 0;
    int tests_passed = 0;
    int tests_failed = 0;

    always #10 ccip_to_afu = ~ccip_to_afu;

    platform_shim UUT
    (
        .ccip_to_afu(ccip_to_afu),
        .reset(reset),
        .mmio_req(mmio_req),
        .mmio_rsp(mmio_rsp),
        .bank_req(bank_req),
        .bank_rsp(bank_rsp)
    );

    mem_bank_model bank0
    (
        .ccip_to_afu(ccip_to_afu),
        .req(bank_req[0]),
        .rsp(bank_rsp[0])
    );

    mem_bank_model bank1
    (
        .ccip_to_afu(ccip_to_afu),
        .req(bank_req[1]),
        .rsp(bank_rsp[1])
    );

    // ====================
    // Expected values
    // ====================

    // Range word i holds the seed on top and seed + i below
    function automatic logic [63:0] expected_word(input logic [31:0] seed, input logic [15:0] idx);
        return {seed, seed + 32'(idx)};
    endfunction

    // A bank write must be local, inside the fill range and carry its pattern word
    function automatic logic write_ok(input logic bank, input logic [`SHIM_BANK_ADDR_W:0] addr,
                                      input logic [63:0] data);
        logic [`SHIM_BANK_ADDR_W:0] gaddr;
        logic [`SHIM_BANK_ADDR_W:0] idx;
        gaddr = {bank, addr[`SHIM_BANK_ADDR_W-1:0]};
        idx = gaddr - fill_base;
        return !addr[`SHIM_BANK_ADDR_W] && ({5'd0, idx} < fill_count)
            && (data == expected_word(fill_seed, {5'd0, idx}));
    endfunction

    function automatic logic [63:0] expected_status();
        ccip_shim_pkg::t_status st;
        st = '0;
        st.fill_done = exp_fill_done;
        st.check_done = exp_check_done;
        st.err_count = exp_err;
        return st;
    endfunction

    // ====================
    // Checks
    // ====================

    // A read strobe is answered on the next cycle, with the expected word when it is checked
    a_mmio_rsp: assert property (@(posedge ccip_to_afu) disable iff (reset)
        mmio_req.rd |=> (mmio_rsp.valid && (!$past(rd_check) || mmio_rsp.data == $past(exp_rsp))))
    else
    begin
        errors++;
        $display("FAILED at %0t: MMIO response valid %b data %h, expected %h",
                 $time, mmio_rsp.valid, mmio_rsp.data, exp_rsp);
    end

    a_quiet: assert property (@(posedge ccip_to_afu) disable iff (reset)
        quiet |-> !(bank_req[0].read || bank_req[0].write || bank_req[1].read || bank_req[1].write))
    else
    begin
        errors++;
        $display("FAILED at %0t: bank request while no engine was started", $time);
    end

    // Steering drives one bank at a time
    a_one_bank: assert property (@(posedge ccip_to_afu) disable iff (reset)
        !((bank_req[0].read || bank_req[0].write) && (bank_req[1].read || bank_req[1].write)))
    else
    begin
        errors++;
        $display("FAILED at %0t: both banks requested in one cycle", $time);
    end

    a_bank0_write: assert property (@(posedge ccip_to_afu) disable iff (reset)
        (bank_req[0].write && !bank_rsp[0].waitrequest)
            |-> write_ok(1'b0, bank_req[0].address, bank_req[0].writedata))
    else
    begin
        errors++;
        $display("FAILED at %0t: bank 0 write addr %h data %h", $time,
                 bank_req[0].address, bank_req[0].writedata);
    end

    a_bank1_write: assert property (@(posedge ccip_to_afu) disable iff (reset)
        (bank_req[1].write && !bank_rsp[1].waitrequest)
            |-> write_ok(1'b1, bank_req[1].address, bank_req[1].writedata))
    else
    begin
        errors++;
        $display("FAILED at %0t: bank 1 write addr %h data %h", $time,
                 bank_req[1].address, bank_req[1].writedata);
    end

    // Accepted beats on both banks, taken before this edge's register updates
    always @(posedge ccip_to_afu)
    begin
        wr_total <= wr_total + int'(bank_req[0].write && !bank_rsp[0].waitrequest)
                             + int'(bank_req[1].write && !bank_rsp[1].waitrequest);
        rd_total <= rd_total + int'(bank_req[0].read && !bank_rsp[0].waitrequest)
                             + int'(bank_req[1].read && !bank_rsp[1].waitrequest);
    end

    always @(posedge ccip_to_afu)
    begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Result: FAILED");
            $finish;
        end
    end

    // ====================
    // Stimulus tasks
    // ====================

    task automatic mmio_write(input logic [`SHIM_MMIO_ADDR_W-1:0] addr, input logic [63:0] data);
        @(negedge ccip_to_afu);
        mmio_req.wr = 1'b1;
        mmio_req.addr = addr;
        mmio_req.data = data;
        @(negedge ccip_to_afu);
        mmio_req.wr = 1'b0;
    endtask

    // The answer comes one cycle after the strobe, compared only when compare is set
    task automatic mmio_read(input logic [`SHIM_MMIO_ADDR_W-1:0] addr, input logic compare,
                             input logic [63:0] exp, output logic [63:0] data);
        @(negedge ccip_to_afu);
        mmio_req.rd = 1'b1;
        mmio_req.addr = addr;
        rd_check = compare;
        exp_rsp = exp;
        @(negedge ccip_to_afu);
        mmio_req.rd = 1'b0;
        data = mmio_rsp.data;
    endtask

    // Poll status until every bit of mask is set
    task automatic wait_status(input logic [63:0] mask);
        logic [63:0] data;
        data = '0;
        while ((data & mask) != mask)
            mmio_read(`SHIM_REG_STATUS, 1'b0, '0, data);
    endtask

    task automatic start_run(input logic [`SHIM_BANK_ADDR_W:0] base, input logic [15:0] count,
                             input logic [31:0] seed, input logic [63:0] ctrl);
        ccip_shim_pkg::t_mmio_word w;
        w.raw = '0;
        w.desc.base = base;
        w.desc.count = count;
        w.desc.seed = seed;
        mmio_write(`SHIM_REG_DESC, w.raw);
        mmio_write(`SHIM_REG_CTRL, ctrl);
    endtask

    task automatic compare_beats(input string what, input int got, input int want);
        assert (got == want)
        else
        begin
            errors++;
            $display("FAILED at %0t: %s took %0d beats, expected %0d", $time, what, got, want);
        end
    endtask

    task automatic status_matches();
        logic [63:0] data;
        mmio_read(`SHIM_REG_STATUS, 1'b1, expected_status(), data);
    endtask

    // Bit 0 of the control word starts a fill, bit 1 a check
    task automatic fill_range(input logic [`SHIM_BANK_ADDR_W:0] base, input logic [15:0] count,
                              input logic [31:0] seed);
        fill_base = base;
        fill_count = count;
        fill_seed = seed;
        wr_mark = wr_total;
        start_run(base, count, seed, 64'h1);
        wait_status(64'h1);
        exp_fill_done = 1'b1;
        compare_beats("fill", wr_total - wr_mark, int'(count));
        status_matches();
    endtask

    task automatic check_range(input logic [`SHIM_BANK_ADDR_W:0] base, input logic [15:0] count,
                               input logic [31:0] seed, input logic [15:0] exp_errors);
        rd_mark = rd_total;
        exp_check_done = 1'b0;
        start_run(base, count, seed, 64'h2);
        wait_status(64'h2);
        exp_check_done = 1'b1;
        exp_err = exp_errors;
        compare_beats("check", rd_total - rd_mark, int'(count));
        status_matches();
    endtask

    task automatic finish_test(input string name);
        if (errors == err_mark)
        begin
            tests_passed++;
            $display("Test %s: ok", name);
        end
        else
        begin
            tests_failed++;
            $display("Test %s: %0d errors", name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    // ====================
    // Test sequence
    // ====================

    initial
    begin
        logic [63:0] data;
        void'($urandom(SEED));
        reset = 1'b1;
        mmio_req = '0;
        rd_check = 1'b0;
        exp_rsp = '0;
        quiet = 1'b1;
        fill_base = '0;
        fill_count = '0;
        fill_seed = '0;
        exp_fill_done = 1'b0;
        exp_check_done = 1'b0;
        exp_err = '0;
        repeat (3) @(posedge ccip_to_afu);
        @(negedge ccip_to_afu);
        reset = 1'b0;

        // Nothing moves after reset and the status word is all zero
        @(negedge ccip_to_afu);
        assert (!mmio_rsp.valid)
        else
        begin
            errors++;
            $display("FAILED at %0t: MMIO response valid after reset", $time);
        end
        mmio_read(`SHIM_REG_STATUS, 1'b1, expected_status(), data);
        finish_test("1 reset state");

        mmio_write(`SHIM_REG_DESC, 64'h8123_4567_89ab_cdef);
        mmio_read(`SHIM_REG_DESC, 1'b1, 64'h8123_4567_89ab_cdef, data);
        finish_test("2 descriptor read-back");

        quiet = 1'b0;
        fill_range(11'h010, 16'(T3_WORDS), SEED_A);
        check_range(11'h010, 16'(T3_WORDS), SEED_A, 16'd0);
        finish_test("3 fill and check in bank 0");

        // The range runs from the end of bank 0 into bank 1
        fill_range(11'h3f0, 16'(T4_WORDS), SEED_B);
        check_range(11'h3f0, 16'(T4_WORDS), SEED_B, 16'd0);
        finish_test("4 range across banks");

        // New fill next to a check of the test 3 range, both engines on the port at once
        fill_base = 11'h100;
        fill_count = 16'(T5_WORDS);
        fill_seed = SEED_C;
        wr_mark = wr_total;
        rd_mark = rd_total;
        exp_check_done = 1'b0;
        start_run(11'h100, 16'(T5_WORDS), SEED_C, 64'h1);
        start_run(11'h010, 16'(T3_WORDS), SEED_A, 64'h2);
        wait_status(64'h3);
        exp_fill_done = 1'b1;
        exp_check_done = 1'b1;
        exp_err = 16'd0;
        compare_beats("joint fill", wr_total - wr_mark, T5_WORDS);
        compare_beats("joint check", rd_total - rd_mark, T3_WORDS);
        status_matches();
        finish_test("5 fill and check together");

        @(negedge ccip_to_afu);
        bank0.corrupt(10'h102);
        bank0.corrupt(10'h105);
        bank0.corrupt(10'h114);
        check_range(11'h100, 16'(T5_WORDS), SEED_C, 16'd3);
        finish_test("6 corrupted words counted");

        $display("Tests run %0d, passed %0d, failed %0d, check errors %0d",
                 tests_passed + tests_failed, tests_passed, tests_failed, errors);
        if (tests_failed == 0 && errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

// File: sources.f
+incdir+verilog
verilog/ccip_shim_pkg.sv
verilog/mem_arbiter.sv
verilog/fill_engine.sv
verilog/check_engine.sv
verilog/mmio_csr.sv
verilog/afu_top.sv
verilog/platform_shim.sv
dv/mem_bank_model.sv
dv/tb_top.sv

// File: verilog/afu_top.sv
module afu_top
(
    input  logic ccip_to_afu,
    input  logic afu_reset,
    input  ccip_shim_pkg::t_mmio_req mmio_req,
    output ccip_shim_pkg::t_mmio_rsp mmio_rsp,
    output ccip_shim_pkg::t_mem_req mem_req,
    input  ccip_shim_pkg::t_mem_rsp mem_rsp
);

    ccip_shim_pkg::t_fill_desc desc;
    ccip_shim_pkg::t_mem_req fill_req;
    ccip_shim_pkg::t_mem_req check_req;
    logic start_fill;
    logic start_check;
    logic fill_done;
    logic check_done;
    logic fill_busy;
    logic check_busy;
    logic fill_wait;
    logic check_wait;
    logic [15:0] err_count;

    // Register block with the descriptor and start controls
    mmio_csr csr
    (
        .ccip_to_afu(ccip_to_afu),
        .reset(afu_reset),
        .mmio_req(mmio_req),
        .mmio_rsp(mmio_rsp),
        .desc(desc),
        .start_fill(start_fill),
        .start_check(start_check),
        .fill_done(fill_done),
        .check_done(check_done),
        .fill_busy(fill_busy),
        .check_busy(check_busy),
        .err_count(err_count)
    );

    fill_engine fill
    (
        .ccip_to_afu(ccip_to_afu),
        .reset(afu_reset),
        .start(start_fill),
        .desc(desc),
        .req(fill_req),
        .waitrequest(fill_wait),
        .busy(fill_busy),
        .done(fill_done)
    );

    // The check engine is the only reader, so read data goes straight to it
    check_engine check
    (
        .ccip_to_afu(ccip_to_afu),
        .reset(afu_reset),
        .start(start_check),
        .desc(desc),
        .req(check_req),
        .waitrequest(check_wait),
        .rsp(mem_rsp),
        .busy(check_busy),
        .done(check_done),
        .err_count(err_count)
    );

    mem_arbiter arb
    (
        .ccip_to_afu(ccip_to_afu),
        .reset(afu_reset),
        .fill_req(fill_req),
        .fill_wait(fill_wait),
        .check_req(check_req),
        .check_wait(check_wait),
        .mem_req(mem_req),
        .mem_rsp(mem_rsp)
    );

endmodule

// File: verilog/ccip_shim_macros.svh
`ifndef CCIP_SHIM_MACROS_SVH
`define CCIP_SHIM_MACROS_SVH

// ====================
// Local memory geometry
// ====================

// Two banks, each addressed by a 10 bit word address
`define SHIM_NUM_BANKS      2
`define SHIM_BANK_ADDR_W    10
`define SHIM_MEM_DATA_W     64

// Reads the check engine may keep in flight at once
`define SHIM_MAX_READS      4

// ====================
// MMIO register map
// ====================

`define SHIM_MMIO_ADDR_W    8
`define SHIM_REG_DESC       8'h00
`define SHIM_REG_CTRL       8'h08
`define SHIM_REG_STATUS     8'h10

`endif

// File: verilog/ccip_shim_pkg.sv
`include "ccip_shim_macros.svh"

package ccip_shim_pkg;

    // Host MMIO channel, at most one strobe per cycle
    typedef struct packed
    {
        logic wr;
        logic rd;
        logic [`SHIM_MMIO_ADDR_W-1:0] addr;
        logic [63:0] data;
    } t_mmio_req;

    typedef struct packed
    {
        logic valid;
        logic [63:0] data;
    } t_mmio_rsp;

    // Base is a global word address; its top bit picks the bank
    typedef struct packed
    {
        logic [4:0] spare;
        logic [31:0] seed;
        logic [15:0] count;
        logic [`SHIM_BANK_ADDR_W:0] base;
    } t_fill_desc;

    typedef struct packed
    {
        logic [61:0] spare;
        logic start_check;
        logic start_fill;
    } t_ctrl_word;

    // One MMIO write word, read as a descriptor or as control by offset
    typedef union packed
    {
        t_fill_desc desc;
        t_ctrl_word ctrl;
        logic [63:0] raw;
    } t_mmio_word;

    typedef struct packed
    {
        logic read;
        logic write;
        logic [`SHIM_BANK_ADDR_W:0] address;
        logic [`SHIM_MEM_DATA_W-1:0] writedata;
    } t_mem_req;

    typedef struct packed
    {
        logic waitrequest;
        logic readdatavalid;
        logic [`SHIM_MEM_DATA_W-1:0] readdata;
    } t_mem_rsp;

    typedef struct packed
    {
        logic [43:0] spare;
        logic [15:0] err_count;
        logic check_busy;
        logic fill_busy;
        logic check_done;
        logic fill_done;
    } t_status;

    // Word i of a range holds the seed above and seed + i below
    function automatic logic [`SHIM_MEM_DATA_W-1:0] pattern_word(
        input logic [31:0] seed,
        input logic [15:0] idx
    );
        pattern_word = {seed, seed + {16'd0, idx}};
    endfunction

endpackage

// File: verilog/check_engine.sv
`include "ccip_shim_macros.svh"

module check_engine
(
    input  logic ccip_to_afu,
    input  logic reset,
    input  logic start,
    input  ccip_shim_pkg::t_fill_desc desc,
    output ccip_shim_pkg::t_mem_req req,
    input  logic waitrequest,
    input  ccip_shim_pkg::t_mem_rsp rsp,
    output logic busy,
    output logic done,
    output logic [15:0] err_count
);

    localparam int CNT_W = $clog2(`SHIM_MAX_READS + 1);

    ccip_shim_pkg::t_fill_desc desc_q;
    logic [15:0] issue_idx;
    logic [15:0] ret_idx;
    logic [CNT_W-1:0] outstanding;
    logic accept;
    logic mismatch;

    // Reads go out back to back while the in-flight window has room
    always_comb
    begin
        req.read = busy && (issue_idx != desc_q.count) && (outstanding < `SHIM_MAX_READS);
        req.write = 1'b0;
        req.address = desc_q.base + issue_idx[`SHIM_BANK_ADDR_W:0];
        req.writedata = '0;
    end

    assign accept = req.read && !waitrequest;

    // Responses come back in order, so the return index names the expected word
    assign mismatch = rsp.readdata != ccip_shim_pkg::pattern_word(desc_q.seed, ret_idx);

    always_ff @(posedge ccip_to_afu)
    begin
        if (reset)
        begin
            busy <= 1'b0;
            done <= 1'b0;
            issue_idx <= '0;
            ret_idx <= '0;
            outstanding <= '0;
            err_count <= '0;
        end
        else
        begin
            done <= 1'b0;
            if (start && !busy)
            begin
                issue_idx <= '0;
                ret_idx <= '0;
                err_count <= '0;
                if (desc.count == '0)
                    done <= 1'b1;
                else
                    busy <= 1'b1;
            end
            else if (busy)
            begin
                if (accept)
                    issue_idx <= issue_idx + 1'b1;
                if (rsp.readdatavalid)
                begin
                    ret_idx <= ret_idx + 1'b1;
                    // The count saturates rather than wrapping
                    if (mismatch && (err_count != '1))
                        err_count <= err_count + 1'b1;
                    // Finished once the last response is in
                    if (ret_idx == desc_q.count - 1'b1)
                    begin
                        busy <= 1'b0;
                        done <= 1'b1;
                    end
                end
            end
            case ({accept, rsp.readdatavalid})
                2'b10:   outstanding <= outstanding + 1'b1;
                2'b01:   outstanding <= outstanding - 1'b1;
                default: outstanding <= outstanding;
            endcase
        end
    end

    always_ff @(posedge ccip_to_afu)
    begin
        if (start && !busy)
            desc_q <= desc;
    end

    // Read data reaches this engine only for reads it issued
    a_no_stray_data: assert property (@(posedge ccip_to_afu) disable iff (reset)
        rsp.readdatavalid |-> (outstanding != '0));

endmodule

// File: verilog/fill_engine.sv
`include "ccip_shim_macros.svh"

module fill_engine
(
    input  logic ccip_to_afu,
    input  logic reset,
    input  logic start,
    input  ccip_shim_pkg::t_fill_desc desc,
    output ccip_shim_pkg::t_mem_req req,
    input  logic waitrequest,
    output logic busy,
    output logic done
);

    ccip_shim_pkg::t_fill_desc desc_q;
    logic [15:0] idx;
    logic accept;

    // One write beat per range word; held until the memory takes it
    always_comb
    begin
        req.read = 1'b0;
        req.write = busy;
        req.address = desc_q.base + idx[`SHIM_BANK_ADDR_W:0];
        req.writedata = ccip_shim_pkg::pattern_word(desc_q.seed, idx);
    end

    assign accept = busy && !waitrequest;

    always_ff @(posedge ccip_to_afu)
    begin
        if (reset)
        begin
            busy <= 1'b0;
            done <= 1'b0;
            idx <= '0;
        end
        else
        begin
            done <= 1'b0;
            if (start && !busy)
            begin
                idx <= '0;
                // An empty range completes at once
                if (desc.count == '0)
                    done <= 1'b1;
                else
                    busy <= 1'b1;
            end
            else if (accept)
            begin
                idx <= idx + 1'b1;
                if (idx == desc_q.count - 1'b1)
                begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // Descriptor is captured once per run
    always_ff @(posedge ccip_to_afu)
    begin
        if (start && !busy)
            desc_q <= desc;
    end

endmodule

// File: verilog/mem_arbiter.sv
module mem_arbiter
(
    input  logic ccip_to_afu,
    input  logic reset,
    input  ccip_shim_pkg::t_mem_req fill_req,
    output logic fill_wait,
    input  ccip_shim_pkg::t_mem_req check_req,
    output logic check_wait,
    output ccip_shim_pkg::t_mem_req mem_req,
    input  ccip_shim_pkg::t_mem_rsp mem_rsp
);

    logic fill_act;
    logic check_act;
    logic mem_act;
    // Select is 0 for the fill engine and 1 for the check engine
    logic sel;
    logic grant_q;
    logic hold_q;
    logic last_q;

    assign fill_act = fill_req.read || fill_req.write;
    assign check_act = check_req.read || check_req.write;

    // A stalled beat keeps its grant; otherwise alternate when both ask
    always_comb
    begin
        if (hold_q)
            sel = grant_q;
        else if (fill_act && check_act)
            sel = !last_q;
        else
            sel = check_act;
    end

    assign mem_req = sel ? check_req : fill_req;
    assign mem_act = mem_req.read || mem_req.write;

    // The engine that lost sees waitrequest high
    assign fill_wait = sel || mem_rsp.waitrequest;
    assign check_wait = !sel || mem_rsp.waitrequest;

    always_ff @(posedge ccip_to_afu)
    begin
        if (reset)
        begin
            grant_q <= 1'b0;
            hold_q <= 1'b0;
            last_q <= 1'b1;
        end
        else
        begin
            grant_q <= sel;
            hold_q <= mem_act && mem_rsp.waitrequest;
            // Round-robin turns over only on an accepted beat
            if (mem_act && !mem_rsp.waitrequest)
                last_q <= sel;
        end
    end

    // Both the grant and the winning engine must hold the beat through a stall
    a_req_stable: assert property (@(posedge ccip_to_afu) disable iff (reset)
        (mem_act && mem_rsp.waitrequest) |=> $stable(mem_req));

endmodule

// File: verilog/mmio_csr.sv
`include "ccip_shim_macros.svh"

module mmio_csr
(
    input  logic ccip_to_afu,
    input  logic reset,
    input  ccip_shim_pkg::t_mmio_req mmio_req,
    output ccip_shim_pkg::t_mmio_rsp mmio_rsp,
    output ccip_shim_pkg::t_fill_desc desc,
    output logic start_fill,
    output logic start_check,
    input  logic fill_done,
    input  logic check_done,
    input  logic fill_busy,
    input  logic check_busy,
    input  logic [15:0] err_count
);

    ccip_shim_pkg::t_mmio_word wr_word;
    ccip_shim_pkg::t_status status;
    logic fill_done_q;
    logic check_done_q;
    logic wr_ctrl;

    // The write data is decoded by offset as a descriptor or a control word
    assign wr_word.raw = mmio_req.data;
    assign wr_ctrl = mmio_req.wr && (mmio_req.addr == `SHIM_REG_CTRL);

    always_comb
    begin
        status = '0;
        status.fill_done = fill_done_q;
        status.check_done = check_done_q;
        status.fill_busy = fill_busy;
        status.check_busy = check_busy;
        status.err_count = err_count;
    end

    // ====================
    // Writes and done flags
    // ====================

    always_ff @(posedge ccip_to_afu)
    begin
        if (reset)
        begin
            desc <= '0;
            start_fill <= 1'b0;
            start_check <= 1'b0;
            fill_done_q <= 1'b0;
            check_done_q <= 1'b0;
            mmio_rsp.valid <= 1'b0;
        end
        else
        begin
            if (mmio_req.wr && (mmio_req.addr == `SHIM_REG_DESC))
                desc <= wr_word.desc;
            // One cycle start pulses; a busy engine drops them itself
            start_fill <= wr_ctrl && wr_word.ctrl.start_fill;
            start_check <= wr_ctrl && wr_word.ctrl.start_check;
            // Done bits stick until the matching start
            if (start_fill)
                fill_done_q <= 1'b0;
            else if (fill_done)
                fill_done_q <= 1'b1;
            if (start_check)
                check_done_q <= 1'b0;
            else if (check_done)
                check_done_q <= 1'b1;
            mmio_rsp.valid <= mmio_req.rd;
        end
    end

    // ====================
    // Read-back
    // ====================

    // Unknown offsets return zero
    always_ff @(posedge ccip_to_afu)
    begin
        if (mmio_req.rd)
        begin
            case (mmio_req.addr)
                `SHIM_REG_DESC:   mmio_rsp.data <= desc;
                `SHIM_REG_STATUS: mmio_rsp.data <= status;
                default:          mmio_rsp.data <= '0;
            endcase
        end
    end

    // The host sends at most one strobe per cycle
    a_one_strobe: assert property (@(posedge ccip_to_afu) disable iff (reset)
        !(mmio_req.rd && mmio_req.wr));

endmodule

// File: verilog/platform_shim.sv
`include "ccip_shim_macros.svh"

module platform_shim
(
    input  logic ccip_to_afu,
    input  logic reset,
    input  ccip_shim_pkg::t_mmio_req mmio_req,
    output ccip_shim_pkg::t_mmio_rsp mmio_rsp,
    output ccip_shim_pkg::t_mem_req bank_req[`SHIM_NUM_BANKS],
    input  ccip_shim_pkg::t_mem_rsp bank_rsp[`SHIM_NUM_BANKS]
);

    localparam int CNT_W = $clog2(`SHIM_MAX_READS + 1);

    ccip_shim_pkg::t_mem_req mem_req;
    ccip_shim_pkg::t_mem_rsp mem_rsp;
    logic afu_reset = 1'b1;
    logic bank_sel;
    logic stall;
    logic rd_accept;
    logic [CNT_W-1:0] rd_cnt;
    logic rd_bank;

    // ====================
    // Reset timing stage
    // ====================

    // The accelerator sees reset one cycle after the platform does
    always_ff @(posedge ccip_to_afu)
    begin
        afu_reset <= reset;
    end

    // ====================
    // Bank steering
    // ====================

    // The top address bit picks the bank
    assign bank_sel = mem_req.address[`SHIM_BANK_ADDR_W];

    // A read to the other bank waits until older reads have drained, so data returns in order
    assign stall = mem_req.read && (rd_cnt != '0) && (rd_bank != bank_sel);
    assign rd_accept = mem_req.read && !mem_rsp.waitrequest;

    for (genvar b = 0; b < `SHIM_NUM_BANKS; b++)
    begin : g_bank
        always_comb
        begin
            bank_req[b].address = {1'b0, mem_req.address[`SHIM_BANK_ADDR_W-1:0]};
            bank_req[b].writedata = mem_req.writedata;
            // Only the selected bank sees the strobes
            bank_req[b].read = mem_req.read && !stall && (bank_sel == b);
            bank_req[b].write = mem_req.write && !stall && (bank_sel == b);
        end
    end

    always_comb
    begin
        mem_rsp.waitrequest = stall || bank_rsp[bank_sel].waitrequest;
        mem_rsp.readdatavalid = bank_rsp[0].readdatavalid || bank_rsp[1].readdatavalid;
        mem_rsp.readdata = bank_rsp[1].readdatavalid ? bank_rsp[1].readdata
                                                     : bank_rsp[0].readdata;
    end

    // Count reads in flight and remember which bank they went to
    always_ff @(posedge ccip_to_afu)
    begin
        if (afu_reset)
        begin
            rd_cnt <= '0;
            rd_bank <= 1'b0;
        end
        else
        begin
            if (rd_accept && !mem_rsp.readdatavalid)
                rd_cnt <= rd_cnt + 1'b1;
            else if (!rd_accept && mem_rsp.readdatavalid)
                rd_cnt <= rd_cnt - 1'b1;
            if (rd_accept)
                rd_bank <= bank_sel;
        end
    end

    // Steering keeps reads on one bank at a time, so both banks never return together
    a_one_bank_returns: assert property (@(posedge ccip_to_afu) disable iff (afu_reset)
        !(bank_rsp[0].readdatavalid && bank_rsp[1].readdatavalid));

    afu_top afu
    (
        .ccip_to_afu(ccip_to_afu),
        .afu_reset(afu_reset),
        .mmio_req(mmio_req),
        .mmio_rsp(mmio_rsp),
        .mem_req(mem_req),
        .mem_rsp(mem_rsp)
    );

endmodule
